/* verification/sbox_trace.txt */
# columns: op, input byte, expected output byte, all hex
# op 0 is the forward S-box, op 1 the inverse S-box
0 00 63
1 7c 01
0 53 ed
1 16 ff
0 10 ca
1 b7 20
0 3c eb
1 d2 7f
0 80 cd
1 06 a5
0 c9 dd
1 94 e7
0 5a be
1 2c 42
0 01 7c
1 63 00
0 ff 16
1 ed 53
0 20 b7
1 ca 10
0 7f d2
1 eb 3c
0 a5 06
1 cd 80
0 e7 94
1 dd c9
0 42 2c
1 be 5a

/* files.f */
+incdir+rtl
rtl/sbox_share_pkg.sv
rtl/sbox_ctrl_pkg.sv
rtl/dom_and.sv
rtl/sbox_in_layer.sv
rtl/gf_inv_mid.sv
rtl/sbox_out_layer.sv
rtl/masked_sbox.sv
verification/sbox_tb.sv

/* Bender.yml */
package:
  name: masked_sbox

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/sbox_share_pkg.sv
      - rtl/sbox_ctrl_pkg.sv
      - rtl/dom_and.sv
      - rtl/sbox_in_layer.sv
      - rtl/gf_inv_mid.sv
      - rtl/sbox_out_layer.sv
      - rtl/masked_sbox.sv
  - target: simulation
    files:
      - verification/sbox_tb.sv

/* verification/sbox_tb.sv */
/*
 * Testbench for the masked AES S-box.
 * Masks trace bytes, runs them back to back, with stalls and across a flush,
 * then unmasks each result and checks value, op and latency.
 */
`timescale 1ns/10ps
`include "sbox_cfg.svh"

module sbox_tb;

    localparam int reset_cycles = 8;
    localparam int stall_max    = 3;
    localparam int flush_idle   = 4;
    localparam int flush_after  = 6;

    typedef struct packed {
        sbox_ctrl_pkg::sbox_op_e op;
        logic [7:0]              din;
        logic [7:0]              dout;
    } trace_t;

    // one request expected back, cap is the enabled edge that took it
    typedef struct packed {
        sbox_ctrl_pkg::sbox_op_e op;
        logic [7:0]              exp;
        int                      cap;
        logic [15:0]             idx;
        logic [1:0]              run;
    } pend_t;

    logic                      g_clk;
    logic                      arst_n;
    logic                      en;
    logic                      flush;
    sbox_ctrl_pkg::sbox_req_t  req;
    sbox_share_pkg::sbox_rnd_t rnd;
    sbox_ctrl_pkg::sbox_rsp_t  rsp;

    trace_t                      trace_q[$];
    pend_t                       pend_q[$];
    pend_t                       drv_item;
    sbox_share_pkg::share_byte_t shares_a[256];
    string                       test_name;
    int byte_errs, op_errs, valid_errs, other_errs;
    int en_edges, cycles, cycle_limit, n;

    masked_sbox DUT (
        .g_clk  (g_clk),
        .arst_n (arst_n),
        .en     (en),
        .flush  (flush),
        .req    (req),
        .rnd    (rnd),
        .rsp    (rsp)
    );

    always #20 g_clk = ~g_clk;

    function automatic logic [7:0] unmask(input sbox_share_pkg::share_byte_t s);
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = ^s[i];
        end
        return b;
    endfunction

    // shares 1 and up random, share 0 closes the XOR to the byte
    function automatic sbox_share_pkg::share_byte_t mask_byte(input logic [7:0] b);
        sbox_share_pkg::share_byte_t s;
        for (int i = 0; i < 8; i++) begin
            s[i]    = sbox_share_pkg::share_bit_t'($urandom);
            s[i][0] = b[i] ^ (^s[i][`SBOX_SHARES-1:1]);
        end
        return s;
    endfunction

    function automatic sbox_share_pkg::sbox_rnd_t fresh_rnd();
        sbox_share_pkg::sbox_rnd_t r;
        for (int g = 0; g < `SBOX_GADGETS; g++) begin
            r[g] = sbox_share_pkg::gadget_rnd_t'($urandom);
        end
        return r;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp,
                              input sbox_share_pkg::share_byte_t act);
        logic [7:0] val;
        val = unmask(act);
        if (val !== exp) begin
            byte_errs++;
            $display("mismatch %s: byte expected %02h actual %02h", name, exp, val);
        end
    endtask

    task automatic check_op(input string name, input sbox_ctrl_pkg::sbox_op_e exp,
                            input sbox_ctrl_pkg::sbox_op_e act);
        if (act !== exp) begin
            op_errs++;
            $display("mismatch %s: op expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            valid_errs++;
            $display("mismatch %s: valid expected %b actual %b at enabled edge %0d",
                     name, exp, act, en_edges);
        end
    endtask

    task automatic load_trace();
        int     fd;
        int     op_v, din_v, dout_v;
        string  line;
        trace_t t;
        fd = $fopen("verification/sbox_trace.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("error: cannot open the trace file verification/sbox_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h", op_v, din_v, dout_v) == 3) begin
                    t.op   = sbox_ctrl_pkg::sbox_op_e'(op_v[0]);
                    t.din  = din_v[7:0];
                    t.dout = dout_v[7:0];
                    trace_q.push_back(t);
                end
            end
        end
        $fclose(fd);
    endtask

    // inputs still hold what the last rising edge saw
    task automatic account_edge();
        pend_t item;
        logic  exp_valid;
        if (!arst_n) begin
            check_valid("reset", 1'b0, rsp.valid);
        end else if (flush) begin
            pend_q.delete();
            check_valid("flush", 1'b0, rsp.valid);
        end else if (en) begin
            en_edges++;
            if (req.valid) begin
                item     = drv_item;
                item.cap = en_edges;
                pend_q.push_back(item);
            end
            exp_valid = (pend_q.size() > 0) &&
                        (pend_q[0].cap + `SBOX_LATENCY - 1 == en_edges);
            check_valid(test_name, exp_valid, rsp.valid);
            if (exp_valid) begin
                item = pend_q.pop_front();
                if (rsp.valid) begin
                    check_byte(test_name, item.exp, rsp.data);
                    check_op(test_name, item.op, rsp.op);
                    if (item.run == 0) begin
                        shares_a[item.idx] = rsp.data;
                    end else if (item.run == 1 && rsp.data === shares_a[item.idx]) begin
                        other_errs++;
                        $display("error: %s output shares of trace line %0d repeat the first run",
                                 test_name, item.idx);
                    end
                end
            end
        end
    endtask

    task automatic step();
        @(negedge g_clk);
        account_edge();
        en        = 1'b1;
        flush     = 1'b0;
        req.valid = 1'b0;
        rnd       = fresh_rnd();
    endtask

    task automatic send(input int k, input int run);
        step();
        req.valid     = 1'b1;
        req.op        = trace_q[k].op;
        req.data      = mask_byte(trace_q[k].din);
        drv_item.op   = trace_q[k].op;
        drv_item.exp  = trace_q[k].dout;
        drv_item.cap  = 0;
        drv_item.idx  = 16'(k);
        drv_item.run  = 2'(run);
    endtask

    // en low with junk on req, none of it may be taken
    task automatic stall(input int len);
        repeat (len) begin
            step();
            en        = 1'b0;
            req.valid = 1'b1;
            req.op    = sbox_ctrl_pkg::sbox_op_e'($urandom % 2);
            req.data  = mask_byte(8'($urandom));
        end
    endtask

    task automatic drain();
        step();
        while (pend_q.size() != 0) begin
            step();
        end
    endtask

    task automatic print_counts();
        $display("errors: byte %0d, op %0d, valid %0d, other %0d",
                 byte_errs, op_errs, valid_errs, other_errs);
    endtask

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge g_clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        print_counts();
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        g_clk  = 1'b0;
        arst_n = 1'b0;
        en     = 1'b0;
        flush  = 1'b0;
        req    = '0;
        rnd    = '0;
        void'($urandom(72));
        load_trace();
        n = trace_q.size();
        if (n == 0) begin
            other_errs++;
            $display("error: the trace holds no entries");
        end
        cycle_limit = 3 * n * `SBOX_LATENCY + n * stall_max + flush_idle + 1 +
                      reset_cycles + 50;

        test_name = "reset";
        repeat (reset_cycles) step();
        arst_n = 1'b1;
        repeat (3) step();

        // both directions, several bytes in flight
        test_name = "back_to_back";
        for (int k = 0; k < n; k++) begin
            send(k, 0);
        end
        drain();

        // same bytes, new masks and rnd, random stalls
        test_name = "stall_remask";
        for (int k = 0; k < n; k++) begin
            if ($urandom % 3 == 0) begin
                stall(1 + $urandom % stall_max);
            end
            send(k, 1);
        end
        drain();

        test_name = "flush";
        for (int k = 0; k < flush_after && k < n; k++) begin
            send(k, 2);
        end
        step();
        flush     = 1'b1;
        en        = 1'b0;
        req.valid = 1'b1;
        repeat (flush_idle) step();
        for (int k = 0; k < n; k++) begin
            send(k, 2);
        end
        drain();

        print_counts();
        if (byte_errs + op_errs + valid_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* rtl/masked_sbox.sv */
/*
 * Masked AES S-box, forward and inverse, one shared byte per enabled cycle.
 * Result appears SBOX_LATENCY enabled cycles after capture; en low stalls
 * the whole pipeline and flush drops everything in flight.
 */
`timescale 1ns/10ps
`include "sbox_cfg.svh"

module masked_sbox (
    input  logic                      g_clk,
    input  logic                      arst_n,
    input  logic                      en,
    input  logic                      flush,
    input  sbox_ctrl_pkg::sbox_req_t  req,
    input  sbox_share_pkg::sbox_rnd_t rnd,
    output sbox_ctrl_pkg::sbox_rsp_t  rsp
);
    localparam int lat = `SBOX_LATENCY;

    // travels beside each byte so the output layer matches its item
    typedef struct packed {
        logic                    valid;
        sbox_ctrl_pkg::sbox_op_e op;
    } tag_t;

    tag_t [lat-1:0]                 tag_q;
    sbox_share_pkg::share_mid_in_t  mid_in;
    sbox_share_pkg::share_mid_out_t mid_out;
    sbox_share_pkg::share_byte_t    out_byte;

    sbox_in_layer u_in (
        .x  (req.data),
        .op (req.op),
        .y  (mid_in)
    );

    gf_inv_mid u_mid (
        .g_clk  (g_clk),
        .arst_n (arst_n),
        .en     (en),
        .flush  (flush),
        .rnd    (rnd),
        .x      (mid_in),
        .y      (mid_out)
    );

    sbox_out_layer u_out (
        .x  (mid_out),
        .op (tag_q[lat-1].op),
        .y  (out_byte)
    );

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_q <= '0;
        end else if (flush) begin
            tag_q <= '0;
        end else if (en) begin
            tag_q <= {tag_q[lat-2:0], req.valid, req.op};
        end
    end

    always_comb begin
        rsp.valid = tag_q[lat-1].valid;
        rsp.op    = tag_q[lat-1].op;
        rsp.data  = out_byte;
    end

endmodule

/* rtl/sbox_out_layer.sv */
/*
 * Bottom linear layers of the forward and inverse AES S-box.
 * Compresses the 18 masked core outputs to a masked byte, op picks the result.
 */
`timescale 1ns/10ps
`include "sbox_cfg.svh"

module sbox_out_layer (
    input  sbox_share_pkg::share_mid_out_t x,
    input  sbox_ctrl_pkg::sbox_op_e        op,
    output sbox_share_pkg::share_byte_t    y
);
    // share 0 only, as in the top layer
    localparam sbox_share_pkg::share_bit_t flip = {{(`SBOX_SHARES - 1){1'b0}}, 1'b1};

    sbox_share_pkg::share_byte_t fwd;
    sbox_share_pkg::share_byte_t inv;

    // forward layer, carries the 0x63 constant
    always_comb begin : fwd_bot
        sbox_share_pkg::share_bit_t t0, t1, t2, t3, t4, t5, t6, t7, t8, t9;
        sbox_share_pkg::share_bit_t t10, t11, t12, t13, t14, t15, t16, t17, t18, t19;
        sbox_share_pkg::share_bit_t t20, t21, t22, t23, t24, t25, t26, t27, t28, t29;
        t0  = x[11] ^ x[12];
        t1  = x[0] ^ x[6];
        t2  = x[14] ^ x[16];
        t3  = x[15] ^ x[5];
        t4  = x[4] ^ x[8];
        t5  = x[17] ^ x[11];
        t6  = x[12] ^ t5;
        t7  = x[14] ^ t3;
        t8  = x[1] ^ x[9];
        t9  = x[2] ^ x[3];
        t10 = x[3] ^ t4;
        t11 = x[10] ^ t2;
        t12 = x[16] ^ x[1];
        t13 = x[0] ^ t0;
        t14 = x[2] ^ x[11];
        t15 = x[5] ^ t1;
        t16 = x[6] ^ t0;
        t17 = x[7] ^ t1;
        t18 = x[8] ^ t8;
        t19 = x[13] ^ t4;
        t20 = t0 ^ t1;
        t21 = t1 ^ t7;
        t22 = t3 ^ t12;
        t23 = t18 ^ t2;
        t24 = t15 ^ t9;
        t25 = t6 ^ t10;
        t26 = t7 ^ t9;
        t27 = t8 ^ t10;
        t28 = t11 ^ t14;
        t29 = t11 ^ t17;
        fwd[0] = t6 ^ t23 ^ flip;
        fwd[1] = t13 ^ t27 ^ flip;
        fwd[2] = t25 ^ t29;
        fwd[3] = t20 ^ t22;
        fwd[4] = t6 ^ t21;
        fwd[5] = t19 ^ t28 ^ flip;
        fwd[6] = t16 ^ t26 ^ flip;
        fwd[7] = t6 ^ t24;
    end

    // inverse layer, purely linear here
    always_comb begin : inv_bot
        sbox_share_pkg::share_bit_t t0, t1, t2, t3, t4, t5, t6, t7, t8, t9;
        sbox_share_pkg::share_bit_t t10, t11, t12, t13, t14, t15, t16, t17, t18, t19;
        sbox_share_pkg::share_bit_t t20, t22, t23, t24, t25, t26, t27, t28, t29;
        t0  = x[2] ^ x[11];
        t1  = x[8] ^ x[9];
        t2  = x[4] ^ x[12];
        t3  = x[15] ^ x[0];
        t4  = x[16] ^ x[6];
        t5  = x[14] ^ x[1];
        t6  = x[17] ^ x[10];
        t7  = t0 ^ t1;
        t8  = x[0] ^ x[3];
        t9  = x[5] ^ x[13];
        t10 = x[7] ^ t4;
        t11 = t0 ^ t3;
        t12 = x[14] ^ x[16];
        t13 = x[17] ^ x[1];
        t14 = x[17] ^ x[12];
        t15 = x[4] ^ x[9];
        t16 = x[7] ^ x[11];
        t17 = x[8] ^ t2;
        t18 = x[13] ^ t5;
        t19 = t2 ^ t3;
        t20 = t4 ^ t6;
        t22 = t2 ^ t7;
        t23 = t7 ^ t8;
        t24 = t5 ^ t7;
        t25 = t6 ^ t10;
        t26 = t9 ^ t11;
        t27 = t10 ^ t18;
        t28 = t11 ^ t25;
        t29 = t15 ^ t20;
        inv[0] = t9 ^ t16;
        inv[1] = t14 ^ t23;
        inv[2] = t19 ^ t24;
        inv[3] = t23 ^ t27;
        inv[4] = t12 ^ t22;
        inv[5] = t17 ^ t28;
        inv[6] = t26 ^ t29;
        inv[7] = t13 ^ t22;
    end

    assign y = (op == sbox_ctrl_pkg::op_dec) ? inv : fwd;

endmodule

/* rtl/gf_inv_mid.sv */
/*
 * Masked nonlinear core shared by both S-box directions (GF(2^8) inversion).
 * Four stages of DOM AND gadgets with XOR networks in between; input bits
 * and linear terms reused later ride along in en-gated delay registers.
 */
`timescale 1ns/10ps
`include "sbox_cfg.svh"

module gf_inv_mid (
    input  logic                           g_clk,
    input  logic                           arst_n,
    input  logic                           en,
    input  logic                           flush,
    input  sbox_share_pkg::sbox_rnd_t      rnd,
    input  sbox_share_pkg::share_mid_in_t  x,
    output sbox_share_pkg::share_mid_out_t y
);
    // input bit pairs of stage 1, and the input bit of each output gadget
    localparam int s1_a [9]  = '{9, 17, 14, 3, 16, 15, 1, 4, 2};
    localparam int s1_b [9]  = '{5, 6, 0, 12, 7, 13, 11, 20, 8};
    localparam int s4_b [18] = '{7, 13, 11, 20, 8, 9, 17, 14, 3, 16, 15, 1, 4, 2, 5, 6, 0, 12};

    // delayed values, suffix names the stage whose network reads them
    typedef struct packed {
        sbox_share_pkg::share_mid_in_t [2:0] xin;
        sbox_share_pkg::share_bit_t          t21_s3, t23_s3, t24_s3, t27_s3;
        sbox_share_pkg::share_bit_t          t21_s4, t23_s4, t33_s4, t36_s4;
    } dly_t;

    dly_t dly;

    sbox_share_pkg::share_bit_t [`SBOX_GADGETS-1:0] and_a, and_b, and_q;
    sbox_share_pkg::share_bit_t [8:0]               s4_a;

    sbox_share_pkg::share_bit_t t0, t1, t2, t3, t4, t5, t6, t7, t8, t9, t10;
    sbox_share_pkg::share_bit_t t11, t12, t13, t14, t15, t16, t17, t18, t19, t20;
    sbox_share_pkg::share_bit_t t21, t22, t23, t24, t25, t26, t27, t28, t29, t30;
    sbox_share_pkg::share_bit_t t31, t32, t33, t34, t35, t36, t37, t38, t39, t40;
    sbox_share_pkg::share_bit_t t41, t42, t43, t44, t45;

    for (genvar k = 0; k < `SBOX_GADGETS; k++) begin : g_and
        dom_and u_and (
            .g_clk  (g_clk),
            .arst_n (arst_n),
            .en     (en),
            .flush  (flush),
            .a      (and_a[k]),
            .b      (and_b[k]),
            .rnd    (rnd[k]),
            .q      (and_q[k])
        );
    end

    // stage 1 reads the top layer directly
    for (genvar k = 0; k < 9; k++) begin : g_s1_ops
        assign and_a[k] = x[s1_a[k]];
        assign and_b[k] = x[s1_b[k]];
    end

    assign t1  = and_q[0];
    assign t2  = and_q[1];
    assign t4  = and_q[2];
    assign t6  = and_q[3];
    assign t7  = and_q[4];
    assign t9  = and_q[5];
    assign t11 = and_q[6];
    assign t12 = and_q[7];
    assign t14 = and_q[8];

    // network after stage 1, input bits taken one cycle late
    assign t0  = dly.xin[0][3] ^ dly.xin[0][12];
    assign t3  = dly.xin[0][10] ^ t1;
    assign t5  = t4 ^ t1;
    assign t8  = t0 ^ t6;
    assign t10 = t9 ^ t6;
    assign t13 = t12 ^ t11;
    assign t15 = t14 ^ t11;
    assign t16 = t3 ^ t2;
    assign t17 = t5 ^ dly.xin[0][18];
    assign t18 = t8 ^ t7;
    assign t19 = t10 ^ t15;
    assign t20 = t16 ^ t13;
    assign t21 = t17 ^ t15;
    assign t22 = t18 ^ t13;
    assign t23 = t19 ^ dly.xin[0][19];
    assign t24 = t22 ^ t23;
    assign t27 = t20 ^ t21;

    assign and_a[9]  = t22;
    assign and_b[9]  = t20;
    assign and_a[10] = t20;
    assign and_b[10] = t23;
    assign and_a[11] = t21;
    assign and_b[11] = t22;

    assign t25 = and_q[9];
    assign t31 = and_q[10];
    assign t34 = and_q[11];

    // network after stage 2
    assign t26 = dly.t21_s3 ^ t25;
    assign t28 = dly.t23_s3 ^ t25;
    assign t33 = dly.t27_s3 ^ t25;
    assign t36 = dly.t24_s3 ^ t25;

    assign and_a[12] = t28;
    assign and_b[12] = dly.t27_s3;
    assign and_a[13] = t26;
    assign and_b[13] = dly.t24_s3;
    assign and_a[14] = dly.t27_s3;
    assign and_b[14] = t31;
    assign and_a[15] = dly.t24_s3;
    assign and_b[15] = t34;

    assign t29 = and_q[12];
    assign t30 = and_q[13];
    assign t32 = and_q[14];
    assign t35 = and_q[15];

    // network after stage 3
    assign t37 = dly.t21_s4 ^ t29;
    assign t38 = t32 ^ dly.t33_s4;
    assign t39 = dly.t23_s4 ^ t30;
    assign t40 = t35 ^ dly.t36_s4;
    assign t41 = t38 ^ t40;
    assign t42 = t37 ^ t39;
    assign t43 = t37 ^ t38;
    assign t44 = t39 ^ t40;
    assign t45 = t42 ^ t41;

    // output gadgets j and j+9 share their left operand
    assign s4_a = {t43, t39, t40, t44, t41, t45, t42, t37, t38};

    for (genvar k = 0; k < 18; k++) begin : g_s4_ops
        assign and_a[16 + k] = s4_a[k % 9];
        assign and_b[16 + k] = dly.xin[2][s4_b[k]];
        assign y[k]          = and_q[16 + k];
    end

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            dly <= '0;
        end else if (flush) begin
            dly <= '0;
        end else if (en) begin
            dly.xin    <= {dly.xin[1:0], x};
            dly.t21_s3 <= t21;
            dly.t23_s3 <= t23;
            dly.t24_s3 <= t24;
            dly.t27_s3 <= t27;
            dly.t21_s4 <= dly.t21_s3;
            dly.t23_s4 <= dly.t23_s3;
            dly.t33_s4 <= t33;
            dly.t36_s4 <= t36;
        end
    end

endmodule

/* rtl/sbox_in_layer.sv */
/*
 * Top linear layers of the forward and inverse AES S-box on a masked byte.
 * Both 21-bit vectors are formed share-wise and op picks one for the core.
 */
`timescale 1ns/10ps
`include "sbox_cfg.svh"

module sbox_in_layer (
    input  sbox_share_pkg::share_byte_t   x,
    input  sbox_ctrl_pkg::sbox_op_e       op,
    output sbox_share_pkg::share_mid_in_t y
);
    // complementing a masked bit only needs share 0
    localparam sbox_share_pkg::share_bit_t flip = {{(`SBOX_SHARES - 1){1'b0}}, 1'b1};

    sbox_share_pkg::share_mid_in_t fwd;
    sbox_share_pkg::share_mid_in_t inv;

    // forward layer
    always_comb begin : fwd_top
        sbox_share_pkg::share_bit_t t0, t1, t2, t3, t4, t5;
        t0      = x[3] ^ x[1];
        t1      = x[6] ^ x[5];
        t2      = x[6] ^ x[2];
        t3      = x[5] ^ x[2];
        t4      = x[4] ^ x[0];
        t5      = x[1] ^ x[0];
        fwd[0]  = x[0];
        fwd[1]  = x[7] ^ x[4];
        fwd[2]  = x[7] ^ x[2];
        fwd[3]  = x[7] ^ x[1];
        fwd[4]  = x[4] ^ x[2];
        fwd[5]  = fwd[1] ^ t0;
        fwd[6]  = x[0] ^ fwd[5];
        fwd[7]  = x[0] ^ t1;
        fwd[8]  = fwd[5] ^ t1;
        fwd[9]  = fwd[3] ^ fwd[4];
        fwd[10] = fwd[5] ^ t2;
        fwd[11] = t0 ^ t2;
        fwd[12] = t0 ^ t3;
        fwd[13] = fwd[7] ^ fwd[12];
        fwd[14] = t1 ^ t4;
        fwd[15] = fwd[1] ^ fwd[14];
        fwd[16] = t1 ^ t5;
        fwd[17] = fwd[2] ^ fwd[16];
        fwd[18] = fwd[2] ^ fwd[8];
        fwd[19] = fwd[15] ^ fwd[13];
        fwd[20] = fwd[1] ^ t3;
    end

    // inverse layer, the affine constant shows up as flips
    always_comb begin : inv_top
        sbox_share_pkg::share_bit_t t0, t1, t2, t3, t4;
        t0      = x[1] ^ x[0];
        t1      = x[6] ^ x[1];
        t2      = x[5] ^ x[2] ^ flip;
        t3      = x[2] ^ x[1] ^ flip;
        t4      = x[5] ^ x[3] ^ flip;
        inv[17] = x[7] ^ x[4];
        inv[16] = x[6] ^ x[4] ^ flip;
        inv[2]  = x[7] ^ x[6] ^ flip;
        inv[1]  = x[4] ^ x[3];
        inv[18] = x[3] ^ x[0] ^ flip;
        inv[6]  = x[6] ^ inv[17] ^ flip;
        inv[14] = inv[16] ^ t0;
        inv[7]  = x[0] ^ inv[1] ^ flip;
        inv[8]  = inv[2] ^ inv[18];
        inv[9]  = inv[2] ^ t0;
        inv[3]  = inv[1] ^ t0;
        inv[19] = x[5] ^ inv[1] ^ flip;
        inv[13] = x[5] ^ inv[14] ^ flip;
        inv[15] = inv[18] ^ t1;
        inv[4]  = x[3] ^ inv[6];
        inv[5]  = inv[16] ^ t2;
        inv[12] = t1 ^ t4;
        inv[20] = inv[1] ^ t3;
        inv[11] = inv[8] ^ inv[20];
        inv[10] = inv[8] ^ t3;
        inv[0]  = x[7] ^ t2;
    end

    assign y = (op == sbox_ctrl_pkg::op_dec) ? inv : fwd;

endmodule

/* rtl/dom_and.sv */
/*
 * Domain-oriented masked AND of two shared bits.
 * All share products are registered, cross-domain ones remasked first,
 * so q follows a and b by one enabled cycle.
 */
`timescale 1ns/10ps
`include "sbox_cfg.svh"

module dom_and (
    input  logic                        g_clk,
    input  logic                        arst_n,
    input  logic                        en,
    input  logic                        flush,
    input  sbox_share_pkg::share_bit_t  a,
    input  sbox_share_pkg::share_bit_t  b,
    input  sbox_share_pkg::gadget_rnd_t rnd,
    output sbox_share_pkg::share_bit_t  q
);
    localparam int n = `SBOX_SHARES;

    // row i collects the terms that sum into domain i
    logic [n-1:0][n-1:0] term_d;
    logic [n-1:0][n-1:0] term_q;

    for (genvar i = 0; i < n; i++) begin : g_dom
        for (genvar j = 0; j < n; j++) begin : g_term
            if (i == j) begin : g_inner
                assign term_d[i][j] = a[i] & b[j];
            end else begin : g_cross
                localparam int lo = (i < j) ? i : j;
                localparam int hi = (i < j) ? j : i;
                // pairs (i,j) and (j,i) reuse the same bit
                localparam int r = lo * n - lo * (lo + 1) / 2 + hi - lo - 1;
                assign term_d[i][j] = (a[i] & b[j]) ^ rnd[r];
            end
        end
        assign q[i] = ^term_q[i];
    end

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            term_q <= '0;
        end else if (flush) begin
            term_q <= '0;
        end else if (en) begin
            term_q <= term_d;
        end
    end

endmodule

/* rtl/sbox_ctrl_pkg.sv */
/*
 * Control types of the masked S-box: direction code plus the request and
 * result words seen at the top-level ports.
 */
package sbox_ctrl_pkg;

    // forward or inverse S-box
    typedef enum logic {
        op_enc = 1'b0,
        op_dec = 1'b1
    } sbox_op_e;

    // one byte going in
    typedef struct packed {
        logic                        valid;
        sbox_op_e                    op;
        sbox_share_pkg::share_byte_t data;
    } sbox_req_t;

    // one byte coming out, op echoes the request
    typedef struct packed {
        logic                        valid;
        sbox_op_e                    op;
        sbox_share_pkg::share_byte_t data;
    } sbox_rsp_t;

endpackage

/* rtl/sbox_share_pkg.sv */
/*
 * Shared-value types of the masked S-box datapath.
 * Element s of a share_bit_t is share s; the XOR of all elements is the bit.
 */
`include "sbox_cfg.svh"

package sbox_share_pkg;

    // one masked bit
    typedef logic [`SBOX_SHARES-1:0] share_bit_t;

    // masked byte, index 7 is the msb
    typedef share_bit_t [7:0] share_byte_t;

    // top linear layer output and middle layer output
    typedef share_bit_t [20:0] share_mid_in_t;
    typedef share_bit_t [17:0] share_mid_out_t;

    // randomness of a single gadget, then of the whole core
    typedef logic [`SBOX_RND_PER_GADGET-1:0] gadget_rnd_t;
    typedef gadget_rnd_t [`SBOX_GADGETS-1:0] sbox_rnd_t;

endpackage

/* rtl/sbox_cfg.svh */
/*
 * Build-time configuration of the masked AES S-box.
 * Included by the packages and the RTL modules that size themselves from it.
 */
`ifndef SBOX_CFG_SVH
`define SBOX_CFG_SVH

// boolean shares per masked bit, masking order is one less
`define SBOX_SHARES 3
// AND gadgets in the inversion core
`define SBOX_GADGETS 34
// one fresh bit per share pair
`define SBOX_RND_PER_GADGET (`SBOX_SHARES * (`SBOX_SHARES - 1) / 2)
// request to result, one register per gadget stage
`define SBOX_LATENCY 4

`endif
